// ==== axis_rate_limit_top.f ====
+incdir+include
rtl/axis_pkg.sv
rtl/rate_pkg.sv
rtl/rate_gate.sv
rtl/axis_skid_reg.sv
rtl/axis_rate_limit_top.sv
tb/axis_rate_limit_checker.sv
tb/tb_axis_rate_limit.sv

// ==== Bender.yml ====
package:
  name: axis_rate_limit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/axis_pkg.sv
      - rtl/rate_pkg.sv
      - rtl/rate_gate.sv
      - rtl/axis_skid_reg.sv
      - rtl/axis_rate_limit_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/axis_rate_limit_checker.sv
      - tb/tb_axis_rate_limit.sv

// ==== tb/tb_axis_rate_limit.sv ====
// testbench for the stream rate limiter
// LFSR stimulus, queue model of the beat stream
// full rate, beat and frame throttling, back-pressure phases

`timescale 1ns/1ns

module tb_axis_rate_limit;
    import axis_pkg::*;
    import rate_pkg::*;

    // beats per phase
    localparam int full_beats  = 300;
    localparam int beat_beats  = 200;
    localparam int frame_beats = 200;
    localparam int stall_beats = 300;
    // largest denom of all phases
    localparam int max_denom   = 4;
    localparam int timeout_cycles =
        4 * (full_beats + beat_beats + frame_beats + stall_beats) * max_denom + 200;

    // phase ids
    localparam int phase_full  = 1;
    localparam int phase_beat  = 2;
    localparam int phase_frame = 3;
    localparam int phase_stall = 4;

    logic       clk;
    logic       rst;
    rate_cfg_t  cfg;
    axis_beat_t s_beat;
    logic       s_valid;
    logic       s_ready;
    axis_beat_t m_beat;
    logic       m_valid;
    logic       m_ready;

    // expected beats in order of acceptance
    axis_beat_t  model_q[$];
    logic [31:0] lfsr_state;

    int error_count;
    int s_count;
    int m_count;
    int cycle_count;
    int run_cycles;

    // per phase bookkeeping
    int   phase_id;
    int   phase_s_count;
    int   phase_first;
    int   phase_last;
    int   frame_len;
    int   longest_frame;
    logic full_rate_ready;

    // frame as seen on the s side
    logic frame_open;
    logic ready_since_open;
    // s transfer due at the coming rising edge
    logic s_fire;

    axis_rate_limit_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .cfg     (cfg),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20;
            clk = ~clk;
        end
    end

    // galois LFSR stepped once per output bit
    function automatic logic next_rand_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'ha300_0000;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], next_rand_bit()};
        end
        return value;
    endfunction

    task automatic check_reset_outputs(input string when);
        if (s_ready !== 1'b0) begin
            error_count++;
            $display("CHECK FAILED s_ready %s: got %h expected 0", when, s_ready);
        end
        if (m_valid !== 1'b0) begin
            error_count++;
            $display("CHECK FAILED m_valid %s: got %h expected 0", when, m_valid);
        end
    endtask

    task automatic compare_beat(input axis_beat_t got, input axis_beat_t want);
        if (got.data !== want.data) begin
            error_count++;
            $display("CHECK FAILED m_beat.data: got %h expected %h", got.data, want.data);
        end
        if (got.last !== want.last) begin
            error_count++;
            $display("CHECK FAILED m_beat.last: got %h expected %h", got.last, want.last);
        end
        if (got.user !== want.user) begin
            error_count++;
            $display("CHECK FAILED m_beat.user: got %h expected %h", got.user, want.user);
        end
    endtask

    // sample both sides on the falling edge
    always @(negedge clk) begin
        axis_beat_t want;
        if (rst === 1'b0) begin
            cycle_count++;

            // line rate keeps s_ready up once it rose
            if (phase_id == phase_full) begin
                if (s_ready) begin
                    full_rate_ready = 1'b1;
                end else if (full_rate_ready) begin
                    error_count++;
                    $display("CHECK FAILED s_ready in the full-rate phase at cycle %0d: %s",
                             cycle_count, $sformatf("got %h expected 1", s_ready));
                end
            end

            // no pause inside an open frame while m_ready held high
            if (phase_id == phase_frame && frame_open && ready_since_open && !s_ready) begin
                error_count++;
                $display("CHECK FAILED s_ready inside an open frame at cycle %0d: %s",
                         cycle_count, $sformatf("got %h expected 1", s_ready));
            end
            if (!m_ready) begin
                ready_since_open = 1'b0;
            end

            // pop the m side before pushing the s side
            if (m_valid && m_ready) begin
                m_count++;
                if (model_q.size() == 0) begin
                    error_count++;
                    $display("m transfer at cycle %0d with no beat in the model", cycle_count);
                end else begin
                    want = model_q.pop_front();
                    compare_beat(m_beat, want);
                end
            end

            s_fire = s_valid && s_ready;
            if (s_fire) begin
                model_q.push_back(s_beat);
                s_count++;
                if (phase_s_count == 0) begin
                    phase_first = cycle_count;
                end
                phase_last = cycle_count;
                phase_s_count++;
                frame_len++;
                if (s_beat.last) begin
                    if (frame_len > longest_frame) begin
                        longest_frame = frame_len;
                    end
                    frame_len  = 0;
                    frame_open = 1'b0;
                end else begin
                    // new frame starts with this beat
                    if (!frame_open) begin
                        ready_since_open = m_ready;
                    end
                    frame_open = 1'b1;
                end
            end
        end
    end

    task automatic finish_run();
        int assert_errors;
        assert_errors = u_dut.u_checker.assert_errors;
        $display("errors: %0d (checks %0d, assertions %0d), s transfers %0d, m transfers %0d",
                 error_count + assert_errors, error_count, assert_errors, s_count, m_count);
        if (error_count == 0 && assert_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // run limit
    always @(posedge clk) begin
        run_cycles++;
        if (run_cycles > timeout_cycles) begin
            error_count++;
            $display("timeout, run still busy after %0d cycles", timeout_cycles);
            finish_run();
        end
    end

    // run one phase with inputs driven 2 ns after the rising edge
    task automatic run_phase(input int id, input int num, input int denom,
                             input logic by_frame, input int beats,
                             input logic random_valid, input logic random_ready);
        int   launched;
        logic launch;
        @(posedge clk);
        #2;
        cfg.num       = rate_t'(num);
        cfg.denom     = rate_t'(denom);
        cfg.by_frame  = by_frame;
        phase_id      = id;
        phase_s_count = 0;
        phase_first   = 0;
        phase_last    = 0;
        frame_len     = 0;
        longest_frame = 0;
        launched      = 0;
        while (phase_s_count < beats) begin
            // a waiting beat stays until taken
            if (!s_valid || s_fire) begin
                s_valid = 1'b0;
                launch  = (launched < beats);
                if (launch && random_valid) begin
                    // gap about one cycle in four
                    launch = (rand_bits(2) != 0);
                end
                if (launch) begin
                    s_beat.data = axis_data_t'(rand_bits($bits(axis_data_t)));
                    s_beat.user = next_rand_bit();
                    s_beat.last = (rand_bits(2) == 0);
                    // close the frame at the end of the phase
                    if (launched == beats - 1) begin
                        s_beat.last = 1'b1;
                    end
                    s_valid = 1'b1;
                    launched++;
                end
            end
            m_ready = random_ready ? next_rand_bit() : 1'b1;
            @(posedge clk);
            #2;
        end
        s_valid = 1'b0;
    endtask

    // wait until the skid register is empty and s_ready is back
    task automatic drain_outputs();
        m_ready = 1'b1;
        while (model_q.size() != 0 || !s_ready) begin
            @(posedge clk);
            #2;
        end
    endtask

    // acceptance span against (beats - 1) * denom / num
    task automatic check_span(input int num, input int denom, input int beats,
                              input int frame_cap);
        int span;
        int expected;
        int slack;
        span     = (phase_last - phase_first) * num;
        expected = (beats - 1) * denom;
        slack    = 2 * denom * frame_cap * num;
        if (span > expected + slack || span < expected - slack) begin
            error_count++;
            $display("%0d beats took %0d cycles, expected %0d give or take %0d",
                     beats, phase_last - phase_first, expected / num, slack / num);
        end
    endtask

    initial begin
        rst              = 1'b1;
        cfg.num          = rate_t'(1);
        cfg.denom        = rate_t'(1);
        cfg.by_frame     = 1'b0;
        s_beat           = '0;
        s_valid          = 1'b0;
        m_ready          = 1'b0;
        lfsr_state       = 32'hae50;
        error_count      = 0;
        s_count          = 0;
        m_count          = 0;
        cycle_count      = 0;
        run_cycles       = 0;
        phase_id         = 0;
        full_rate_ready  = 1'b0;
        frame_open       = 1'b0;
        ready_since_open = 1'b0;
        s_fire           = 1'b0;

        repeat (3) begin
            @(posedge clk);
            #2;
            check_reset_outputs("during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check_reset_outputs("in the first cycle after reset");

        // line rate without gaps or stalls
        run_phase(phase_full, 1, 1, 1'b0, full_beats, 1'b0, 1'b0);
        drain_outputs();
        if (phase_last - phase_first != full_beats - 1) begin
            error_count++;
            $display("%0d beats at line rate took %0d cycles instead of %0d",
                     full_beats, phase_last - phase_first + 1, full_beats);
        end

        // one beat in four
        run_phase(phase_beat, 1, 4, 1'b0, beat_beats, 1'b0, 1'b0);
        drain_outputs();
        check_span(1, 4, beat_beats, 1);

        // one in three with pauses only between frames
        run_phase(phase_frame, 1, 3, 1'b1, frame_beats, 1'b0, 1'b0);
        drain_outputs();
        check_span(1, 3, frame_beats, longest_frame);

        // random gaps and m_ready stalls
        run_phase(phase_stall, 3, 4, 1'b0, stall_beats, 1'b1, 1'b1);
        drain_outputs();

        // nothing lost or doubled
        if (model_q.size() != 0 || s_count != m_count) begin
            error_count++;
            $display("%0d beats went in, %0d came out, %0d still in the model",
                     s_count, m_count, model_q.size());
        end
        finish_run();
    end

endmodule

// ==== tb/axis_rate_limit_checker.sv ====
// handshake and reset assertions for the stream rate limiter
// bound into axis_rate_limit_top, counts its own failures

`timescale 1ns/1ns

module axis_rate_limit_checker
    import axis_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input axis_beat_t s_beat,
    input logic       s_valid,
    input logic       s_ready,
    input axis_beat_t m_beat,
    input logic       m_valid,
    input logic       m_ready
);

    // failed assertions so far, read by the testbench at the end
    int assert_errors = 0;

    // upstream valid held until taken
    s_valid_hold: assert property (@(posedge clk) disable iff (rst)
        s_valid && !s_ready |=> s_valid)
    else begin
        assert_errors++;
        $error("s_valid dropped before its transfer");
    end

    // upstream beat frozen while waiting
    s_beat_hold: assert property (@(posedge clk) disable iff (rst)
        s_valid && !s_ready |=> $stable(s_beat))
    else begin
        assert_errors++;
        $error("s_beat changed while waiting for s_ready");
    end

    // same rules on the output side
    m_valid_hold: assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid)
    else begin
        assert_errors++;
        $error("m_valid dropped before its transfer");
    end

    m_beat_hold: assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> $stable(m_beat))
    else begin
        assert_errors++;
        $error("m_beat changed while waiting for m_ready");
    end

    // synchronous reset clears both handshake outputs one edge later
    reset_quiet: assert property (@(posedge clk)
        rst |=> !s_ready && !m_valid)
    else begin
        assert_errors++;
        $error("s_ready or m_valid high after a reset edge");
    end

endmodule

bind axis_rate_limit_top axis_rate_limit_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready)
);

// ==== rtl/axis_rate_limit_top.sv ====
// top level of the stream rate limiter
// rate gate feeding the output skid register

`timescale 1ns/1ns

module axis_rate_limit_top
    import axis_pkg::*;
    import rate_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // rate setting, level input
    input  rate_cfg_t  cfg,

    // input stream
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,

    // throttled output stream
    output axis_beat_t m_beat,
    output logic       m_valid,
    input  logic       m_ready
);

    // gate to skid link
    axis_beat_t gate_beat;
    logic       gate_valid;

    // skid room hint back to the gate
    logic       ready_early;

    rate_gate u_gate (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .s_beat      (s_beat),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .gate_beat   (gate_beat),
        .gate_valid  (gate_valid),
        .ready_early (ready_early)
    );

    // one cycle of latency when not stalled
    axis_skid_reg u_skid (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (gate_beat),
        .in_valid    (gate_valid),
        .ready_early (ready_early),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready)
    );

endmodule

// ==== rtl/axis_skid_reg.sv ====
// output skid register for the stream rate limiter
// output slot plus temp slot, keeps full rate under back-pressure

`timescale 1ns/1ns

module axis_skid_reg
    import axis_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // from the rate gate, one-cycle pulse per accepted beat
    input  axis_beat_t in_beat,
    input  logic       in_valid,

    // can take a beat next cycle
    output logic       ready_early,

    // downstream side
    output axis_beat_t m_beat,
    output logic       m_valid,
    input  logic       m_ready
);

    // output slot
    axis_beat_t out_reg;
    logic       out_valid;
    logic       out_valid_next;

    // temp slot, catches a beat while output is stalled
    axis_beat_t temp_reg;
    logic       temp_valid;
    logic       temp_valid_next;

    // last cycle's ready_early, what upstream saw as ready now
    logic ready_reg;

    // steering decisions for the payload registers
    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    assign m_beat  = out_reg;
    assign m_valid = out_valid;

    // room next cycle unless temp is taken or it is about to be
    assign ready_early = m_ready | (~temp_valid & (~out_valid | ~in_valid));

    always_comb begin
        out_valid_next    = out_valid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_reg) begin
            // upstream may be presenting a beat this cycle
            if (m_ready | ~out_valid) begin
                // output drains or is empty
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stuck, park it
                temp_valid_next  = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (m_ready) begin
            // nothing new, move temp up
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            ready_reg  <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            ready_reg  <= ready_early;
        end
    end

    // payload, qualified by the valid flags above
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_reg <= in_beat;
        end else if (store_temp_to_out) begin
            out_reg <= temp_reg;
        end

        if (store_in_to_temp) begin
            temp_reg <= in_beat;
        end
    end

endmodule

// ==== rtl/rate_gate.sv ====
// rate gate for the stream rate limiter
// credit accumulator, open-frame tracking and registered s_ready

`timescale 1ns/1ns

module rate_gate
    import axis_pkg::*;
    import rate_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // rate setting, taken as a live level
    input  rate_cfg_t  cfg,

    // upstream side
    input  axis_beat_t s_beat,
    input  logic       s_valid,
    output logic       s_ready,

    // toward the skid register
    output axis_beat_t gate_beat,
    output logic       gate_valid,
    input  logic       ready_early
);

    // credit state
    acc_t acc_reg;
    acc_t acc_next;

    // num and (denom - num) widened to accumulator size
    acc_t num_ext;
    acc_t step_up;

    // high while a frame has started but its last beat not yet seen
    logic frame_reg;
    logic frame_next;

    logic accept;
    logic pause;
    logic ready_next;

    assign num_ext = acc_t'(cfg.num);
    assign step_up = acc_t'(cfg.denom) - acc_t'(cfg.num);

    // s_ready is registered so this never loops back through valid
    assign accept = s_valid & s_ready;

    always_comb begin
        acc_next   = acc_reg;
        frame_next = frame_reg;
        pause      = 1'b0;

        // idle cycle pays back num worth of debt
        if (acc_reg >= num_ext) begin
            acc_next = acc_reg - num_ext;
        end

        // accepted beat costs denom - num
        if (accept) begin
            frame_next = ~s_beat.last;
            acc_next   = acc_reg + step_up;
        end

        // still owing at least one beat's credit
        if (acc_next >= num_ext) begin
            if (cfg.by_frame) begin
                // frame mode only stops between frames
                pause = ~frame_next;
            end else begin
                pause = 1'b1;
            end
        end

        // skid register must have room as well
        ready_next = ready_early & ~pause;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_reg   <= '0;
            frame_reg <= 1'b0;
            s_ready   <= 1'b0;
        end else begin
            acc_reg   <= acc_next;
            frame_reg <= frame_next;
            s_ready   <= ready_next;
        end
    end

    // beat goes through as is, valid only on an accepted cycle
    assign gate_beat  = s_beat;
    assign gate_valid = accept;

endmodule

// ==== rtl/rate_pkg.sv ====
// rate configuration types for the rate limiter
// rate count, accumulator and the cfg struct

package rate_pkg;

    `include "rate_limit_params.svh"

    // beat or cycle count in the rate fraction
    typedef logic [`RL_RATE_WIDTH-1:0] rate_t;

    // accumulated credit debt
    typedef logic [`RL_ACC_WIDTH-1:0] acc_t;

    // num beats per denom cycles, optional frame-only pausing
    typedef struct packed {
        rate_t num;
        rate_t denom;
        logic  by_frame;
    } rate_cfg_t;

endpackage

// ==== rtl/axis_pkg.sv ====
// stream types for the rate limiter
// payload vector and the beat struct passed between blocks

package axis_pkg;

    `include "rate_limit_params.svh"

    // one beat's payload
    typedef logic [`RL_DATA_WIDTH-1:0] axis_data_t;

    // full beat as it travels with valid/ready
    typedef struct packed {
        axis_data_t data;
        // end of frame marker
        logic       last;
        // sideband flag, passed through untouched
        logic       user;
    } axis_beat_t;

endpackage

// ==== include/rate_limit_params.svh ====
// width macros for the stream rate limiter
// data, rate field and credit accumulator widths

`ifndef RATE_LIMIT_PARAMS_SVH
`define RATE_LIMIT_PARAMS_SVH

// payload bits per beat
`define RL_DATA_WIDTH 8

// rate_num and rate_denom field width
`define RL_RATE_WIDTH 8

// credit accumulator, wide enough for long bursts of debt
`define RL_ACC_WIDTH 24

`endif
